// ==== src/rob_params.svh ====
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// Buffer geometry
`define ROB_DEPTH     8
`define ROB_ID_W      3

// Group and report widths
`define DISP_SIZE     2
`define LANE_W        1
`define CMT_BUS_SIZE  2

`define VADDR_W       32

`endif

// ==== src/rob_pkg.sv ====
package rob_pkg;

  // Exception cause codes, RISC-V numbering
  typedef enum logic [3:0] {
    NONE         = 4'd0,
    ILLEGAL_INST = 4'd2,
    LOAD_FAULT   = 4'd5,
    STORE_FAULT  = 4'd7,
    ECALL        = 4'd11
  } except_e;

  typedef logic [27:0] tval_t;
  typedef logic [30:0] target_t;  // Halfword address

  typedef struct packed {
    logic    redirect;
    target_t target;
  } done_norm_t;

  typedef struct packed {
    except_e cause;
    tval_t   tval;
  } done_exc_t;

  // One 32-bit report word, view picked by the except flag beside it
  typedef union packed {
    done_norm_t norm;
    done_exc_t  exc;
  } done_info_u;

endpackage

// ==== src/rob_dispatch.sv ====
`timescale 1ns/1ps
`include "rob_params.svh"

module rob_dispatch (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_disp_valid,
  input  logic [`ROB_ID_W:0]   i_head_id,
  input  logic                 i_flush,
  output logic                 o_disp_ready,
  output logic                 o_load_valid,
  output logic [`ROB_ID_W-1:0] o_load_id,
  output logic [`ROB_ID_W-1:0] o_disp_cmt_id
);

  logic [`ROB_ID_W:0] r_tail;   // MSB is the wrap bit
  logic [`ROB_ID_W:0] w_count;

  assign w_count      = r_tail - i_head_id;
  assign o_disp_ready = (w_count != `ROB_DEPTH);

  // Group offered on a flush edge is dropped
  assign o_load_valid  = i_disp_valid & o_disp_ready & ~i_flush;
  assign o_load_id     = r_tail[`ROB_ID_W-1:0];
  assign o_disp_cmt_id = r_tail[`ROB_ID_W-1:0];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_tail <= '0;
    end else if (i_flush) begin
      r_tail <= '0;
    end else if (o_load_valid) begin
      r_tail <= r_tail + 1'b1;
    end
  end

  // Tail may catch up with the head but never overtake it
  a_tail_bound : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    w_count <= `ROB_DEPTH
  );

endmodule

// ==== src/rob_entry.sv ====
`timescale 1ns/1ps
`include "rob_params.svh"

module rob_entry
  import rob_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  input  logic                  i_load_valid,
  input  logic [`DISP_SIZE-1:0] i_load_lane_valid,
  input  logic [`VADDR_W-1:0]   i_load_pc,
  input  logic [`DISP_SIZE-1:0] i_load_illegal,

  input  logic [`DISP_SIZE-1:0] i_done_hit,
  input  logic [`DISP_SIZE-1:0] i_done_except,
  input  done_info_u            i_done_info [`DISP_SIZE],

  input  logic                  i_commit_finish,
  input  logic                  i_kill,

  output logic                  o_valid,
  output logic [`DISP_SIZE-1:0] o_lane_valid,
  output logic [`VADDR_W-1:0]   o_pc,
  output logic [`DISP_SIZE-1:0] o_except,
  output except_e               o_cause [`DISP_SIZE],
  output tval_t                 o_tval [`DISP_SIZE],
  output logic [`DISP_SIZE-1:0] o_redirect,
  output target_t               o_target [`DISP_SIZE],
  output logic                  o_all_done
);

  logic                  r_valid;
  logic [`DISP_SIZE-1:0] r_lane_valid;
  logic [`DISP_SIZE-1:0] r_done;
  logic [`DISP_SIZE-1:0] r_except;
  logic [`DISP_SIZE-1:0] r_redirect;
  logic [`VADDR_W-1:0]   r_pc;
  except_e               r_cause [`DISP_SIZE];
  tval_t                 r_tval [`DISP_SIZE];
  target_t               r_target [`DISP_SIZE];

  // --------------------------------------------------
  // Lane status
  // --------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid      <= 1'b0;
      r_lane_valid <= '0;
      r_done       <= '0;
      r_except     <= '0;
      r_redirect   <= '0;
    end else if (i_kill | i_commit_finish) begin
      r_valid    <= 1'b0;
      r_done     <= '0;
      r_except   <= '0;
      r_redirect <= '0;
    end else if (i_load_valid) begin
      r_valid      <= 1'b1;
      r_lane_valid <= i_load_lane_valid;
      r_done       <= i_load_lane_valid & i_load_illegal;  // Illegal is done at once
      r_except     <= i_load_lane_valid & i_load_illegal;
      r_redirect   <= '0;
    end else begin
      for (int d = 0; d < `DISP_SIZE; d++) begin
        if (i_done_hit[d]) begin
          r_done[d]     <= 1'b1;
          r_except[d]   <= i_done_except[d];
          r_redirect[d] <= ~i_done_except[d] & i_done_info[d].norm.redirect;
        end
      end
    end
  end

  // --------------------------------------------------
  // Payload
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_load_valid) begin
      r_pc <= i_load_pc;
      for (int d = 0; d < `DISP_SIZE; d++) begin
        r_cause[d]  <= i_load_illegal[d] ? ILLEGAL_INST : NONE;
        r_tval[d]   <= '0;
        r_target[d] <= '0;
      end
    end else begin
      for (int d = 0; d < `DISP_SIZE; d++) begin
        if (i_done_hit[d] && i_done_except[d]) begin
          r_cause[d] <= i_done_info[d].exc.cause;
          r_tval[d]  <= i_done_info[d].exc.tval;
        end else if (i_done_hit[d]) begin
          r_target[d] <= i_done_info[d].norm.target;
        end
      end
    end
  end

  assign o_valid      = r_valid;
  assign o_lane_valid = r_lane_valid;
  assign o_pc         = r_pc;
  assign o_except     = r_except;
  assign o_cause      = r_cause;
  assign o_tval       = r_tval;
  assign o_redirect   = r_redirect;
  assign o_target     = r_target;
  assign o_all_done   = r_valid & ((r_done & r_lane_valid) == r_lane_valid);

  // Execution units only report on groups still in flight
  a_hit_on_valid : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    |i_done_hit |-> r_valid
  );

endmodule

// ==== src/rob_buffer.sv ====
`timescale 1ns/1ps
`include "rob_params.svh"

module rob_buffer
  import rob_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  input  logic                  i_load_valid,
  input  logic [`ROB_ID_W-1:0]  i_load_id,
  input  logic [`DISP_SIZE-1:0] i_disp_lane_valid,
  input  logic [`VADDR_W-1:0]   i_disp_pc,
  input  logic [`DISP_SIZE-1:0] i_disp_illegal,

  input  logic [`CMT_BUS_SIZE-1:0] i_done_valid,
  input  logic [`ROB_ID_W-1:0]     i_done_cmt_id [`CMT_BUS_SIZE],
  input  logic [`LANE_W-1:0]       i_done_lane [`CMT_BUS_SIZE],
  input  logic [`CMT_BUS_SIZE-1:0] i_done_except,
  input  done_info_u               i_done_info [`CMT_BUS_SIZE],

  input  logic [`ROB_ID_W:0]    i_head_id,
  input  logic                  i_commit_finish,
  input  logic                  i_flush,

  output logic                  o_head_valid,
  output logic [`DISP_SIZE-1:0] o_head_lane_valid,
  output logic [`VADDR_W-1:0]   o_head_pc,
  output logic [`DISP_SIZE-1:0] o_head_except,
  output except_e               o_head_cause [`DISP_SIZE],
  output tval_t                 o_head_tval [`DISP_SIZE],
  output logic [`DISP_SIZE-1:0] o_head_redirect,
  output target_t               o_head_target [`DISP_SIZE],
  output logic                  o_head_all_done
);

  logic [`ROB_ID_W-1:0]  w_head_idx;
  logic [`ROB_DEPTH-1:0] w_valid;
  logic [`ROB_DEPTH-1:0] w_all_done;
  logic [`DISP_SIZE-1:0] w_lane_valid [`ROB_DEPTH];
  logic [`VADDR_W-1:0]   w_pc [`ROB_DEPTH];
  logic [`DISP_SIZE-1:0] w_except [`ROB_DEPTH];
  except_e               w_cause [`ROB_DEPTH][`DISP_SIZE];
  tval_t                 w_tval [`ROB_DEPTH][`DISP_SIZE];
  logic [`DISP_SIZE-1:0] w_redirect [`ROB_DEPTH];
  target_t               w_target [`ROB_DEPTH][`DISP_SIZE];

  assign w_head_idx = i_head_id[`ROB_ID_W-1:0];

  for (genvar e = 0; e < `ROB_DEPTH; e++) begin : g_entry
    logic [`DISP_SIZE-1:0] w_hit;
    logic [`DISP_SIZE-1:0] w_hit_except;
    done_info_u            w_hit_info [`DISP_SIZE];

    // Steer matching report to its lane
    always_comb begin
      for (int d = 0; d < `DISP_SIZE; d++) begin
        w_hit[d]        = 1'b0;
        w_hit_except[d] = 1'b0;
        w_hit_info[d]   = '0;
        for (int p = 0; p < `CMT_BUS_SIZE; p++) begin
          if (i_done_valid[p] && i_done_cmt_id[p] == `ROB_ID_W'(e) &&
              i_done_lane[p] == `LANE_W'(d)) begin
            w_hit[d]        = 1'b1;
            w_hit_except[d] = i_done_except[p];
            w_hit_info[d]   = i_done_info[p];
          end
        end
      end
    end

    rob_entry u_entry (
      .i_clk             (i_clk),
      .i_reset_n         (i_reset_n),
      .i_load_valid      (i_load_valid && i_load_id == `ROB_ID_W'(e)),
      .i_load_lane_valid (i_disp_lane_valid),
      .i_load_pc         (i_disp_pc),
      .i_load_illegal    (i_disp_illegal),
      .i_done_hit        (w_hit),
      .i_done_except     (w_hit_except),
      .i_done_info       (w_hit_info),
      .i_commit_finish   (i_commit_finish && w_head_idx == `ROB_ID_W'(e)),
      .i_kill            (i_flush),
      .o_valid           (w_valid[e]),
      .o_lane_valid      (w_lane_valid[e]),
      .o_pc              (w_pc[e]),
      .o_except          (w_except[e]),
      .o_cause           (w_cause[e]),
      .o_tval            (w_tval[e]),
      .o_redirect        (w_redirect[e]),
      .o_target          (w_target[e]),
      .o_all_done        (w_all_done[e])
    );
  end

  // Head read-out
  assign o_head_valid      = w_valid[w_head_idx];
  assign o_head_all_done   = w_all_done[w_head_idx];
  assign o_head_lane_valid = w_lane_valid[w_head_idx];
  assign o_head_pc         = w_pc[w_head_idx];
  assign o_head_except     = w_except[w_head_idx];
  assign o_head_cause      = w_cause[w_head_idx];
  assign o_head_tval       = w_tval[w_head_idx];
  assign o_head_redirect   = w_redirect[w_head_idx];
  assign o_head_target     = w_target[w_head_idx];

  // Two execution units never finish the same instruction together
  for (genvar p = 0; p < `CMT_BUS_SIZE; p++) begin : g_rpt_chk
    for (genvar q = p + 1; q < `CMT_BUS_SIZE; q++) begin : g_pair
      a_one_rpt_per_lane : assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        !(i_done_valid[p] && i_done_valid[q] &&
          i_done_cmt_id[p] == i_done_cmt_id[q] && i_done_lane[p] == i_done_lane[q])
      );
    end
  end

endmodule

// ==== src/rob_commit.sv ====
`timescale 1ns/1ps
`include "rob_params.svh"

module rob_commit
  import rob_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  input  logic                  i_head_valid,
  input  logic [`DISP_SIZE-1:0] i_head_lane_valid,
  input  logic [`VADDR_W-1:0]   i_head_pc,
  input  logic [`DISP_SIZE-1:0] i_head_except,
  input  except_e               i_head_cause [`DISP_SIZE],
  input  tval_t                 i_head_tval [`DISP_SIZE],
  input  logic [`DISP_SIZE-1:0] i_head_redirect,
  input  target_t               i_head_target [`DISP_SIZE],
  input  logic                  i_head_all_done,

  output logic [`ROB_ID_W:0]    o_head_id,
  output logic                  o_commit_finish,
  output logic                  o_flush,

  output logic                  o_commit_valid,
  output logic [`DISP_SIZE-1:0] o_commit_lanes,
  output logic [`ROB_ID_W-1:0]  o_commit_cmt_id,
  output logic                  o_flush_valid,
  output logic                  o_flush_is_except,
  output except_e               o_flush_cause,
  output tval_t                 o_flush_tval,
  output logic [`VADDR_W-1:0]   o_flush_addr
);

  logic [`ROB_ID_W:0]    r_head;
  logic                  w_found;
  logic [`LANE_W-1:0]    w_sel;      // Oldest excepting or redirecting lane
  logic [`DISP_SIZE-1:0] w_lanes;
  logic [`VADDR_W-1:0]   w_lane_pc;

  always_comb begin
    w_found = 1'b0;
    w_sel   = '0;
    for (int d = `DISP_SIZE - 1; d >= 0; d--) begin
      if (i_head_lane_valid[d] && (i_head_except[d] || i_head_redirect[d])) begin
        w_found = 1'b1;
        w_sel   = `LANE_W'(d);
      end
    end
  end

  // Lanes older than the event retire; a redirecting lane retires itself too
  always_comb begin
    for (int d = 0; d < `DISP_SIZE; d++) begin
      w_lanes[d] = i_head_lane_valid[d] &
                   (!w_found || `LANE_W'(d) < w_sel ||
                    (`LANE_W'(d) == w_sel && !i_head_except[d]));
    end
  end

  assign w_lane_pc       = i_head_pc + (`VADDR_W'(w_sel) << 2);
  assign o_commit_finish = i_head_valid & i_head_all_done;
  assign o_flush         = o_commit_finish & w_found;
  assign o_head_id       = r_head;

  // --------------------------------------------------
  // Head pointer and strobes
  // --------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head         <= '0;
      o_commit_valid <= 1'b0;
      o_flush_valid  <= 1'b0;
    end else begin
      o_commit_valid <= o_commit_finish & (|w_lanes);
      o_flush_valid  <= o_flush;
      if (o_flush) begin
        r_head <= '0;
      end else if (o_commit_finish) begin
        r_head <= r_head + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_commit_finish) begin
      o_commit_lanes    <= w_lanes;
      o_commit_cmt_id   <= r_head[`ROB_ID_W-1:0];
      o_flush_is_except <= i_head_except[w_sel];
      o_flush_cause     <= i_head_except[w_sel] ? i_head_cause[w_sel] : NONE;
      o_flush_tval      <= i_head_except[w_sel] ? i_head_tval[w_sel] : '0;
      o_flush_addr      <= i_head_except[w_sel] ? w_lane_pc
                                                : {i_head_target[w_sel], 1'b0};
    end
  end

  // A flush with nothing retired only comes from an excepting lane 0
  a_flush_needs_commit : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (o_flush_valid && !o_commit_valid) |-> (o_flush_is_except && $past(i_head_except[0]))
  );

endmodule

// ==== src/rob_top.sv ====
`timescale 1ns/1ps
`include "rob_params.svh"

module rob_top
  import rob_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  input  logic                     i_disp_valid,
  input  logic [`DISP_SIZE-1:0]    i_disp_lane_valid,
  input  logic [`VADDR_W-1:0]      i_disp_pc,
  input  logic [`DISP_SIZE-1:0]    i_disp_illegal,
  output logic                     o_disp_ready,
  output logic [`ROB_ID_W-1:0]     o_disp_cmt_id,

  input  logic [`CMT_BUS_SIZE-1:0] i_done_valid,
  input  logic [`ROB_ID_W-1:0]     i_done_cmt_id [`CMT_BUS_SIZE],
  input  logic [`LANE_W-1:0]       i_done_lane [`CMT_BUS_SIZE],
  input  logic [`CMT_BUS_SIZE-1:0] i_done_except,
  input  done_info_u               i_done_info [`CMT_BUS_SIZE],

  output logic                     o_commit_valid,
  output logic [`DISP_SIZE-1:0]    o_commit_lanes,
  output logic [`ROB_ID_W-1:0]     o_commit_cmt_id,
  output logic                     o_flush_valid,
  output logic                     o_flush_is_except,
  output except_e                  o_flush_cause,
  output tval_t                    o_flush_tval,
  output logic [`VADDR_W-1:0]      o_flush_addr
);

  logic                  w_load_valid;
  logic [`ROB_ID_W-1:0]  w_load_id;
  logic [`ROB_ID_W:0]    w_head_id;
  logic                  w_flush;
  logic                  w_commit_finish;

  // Head entry fields
  logic                  w_head_valid;
  logic                  w_head_all_done;
  logic [`DISP_SIZE-1:0] w_head_lane_valid;
  logic [`VADDR_W-1:0]   w_head_pc;
  logic [`DISP_SIZE-1:0] w_head_except;
  except_e               w_head_cause [`DISP_SIZE];
  tval_t                 w_head_tval [`DISP_SIZE];
  logic [`DISP_SIZE-1:0] w_head_redirect;
  target_t               w_head_target [`DISP_SIZE];

  rob_dispatch u_dispatch (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_disp_valid  (i_disp_valid),
    .i_head_id     (w_head_id),
    .i_flush       (w_flush),
    .o_disp_ready  (o_disp_ready),
    .o_load_valid  (w_load_valid),
    .o_load_id     (w_load_id),
    .o_disp_cmt_id (o_disp_cmt_id)
  );

  rob_buffer u_buffer (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_load_valid      (w_load_valid),
    .i_load_id         (w_load_id),
    .i_disp_lane_valid (i_disp_lane_valid),
    .i_disp_pc         (i_disp_pc),
    .i_disp_illegal    (i_disp_illegal),
    .i_done_valid      (i_done_valid),
    .i_done_cmt_id     (i_done_cmt_id),
    .i_done_lane       (i_done_lane),
    .i_done_except     (i_done_except),
    .i_done_info       (i_done_info),
    .i_head_id         (w_head_id),
    .i_commit_finish   (w_commit_finish),
    .i_flush           (w_flush),
    .o_head_valid      (w_head_valid),
    .o_head_lane_valid (w_head_lane_valid),
    .o_head_pc         (w_head_pc),
    .o_head_except     (w_head_except),
    .o_head_cause      (w_head_cause),
    .o_head_tval       (w_head_tval),
    .o_head_redirect   (w_head_redirect),
    .o_head_target     (w_head_target),
    .o_head_all_done   (w_head_all_done)
  );

  rob_commit u_commit (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_head_valid      (w_head_valid),
    .i_head_lane_valid (w_head_lane_valid),
    .i_head_pc         (w_head_pc),
    .i_head_except     (w_head_except),
    .i_head_cause      (w_head_cause),
    .i_head_tval       (w_head_tval),
    .i_head_redirect   (w_head_redirect),
    .i_head_target     (w_head_target),
    .i_head_all_done   (w_head_all_done),
    .o_head_id         (w_head_id),
    .o_commit_finish   (w_commit_finish),
    .o_flush           (w_flush),
    .o_commit_valid    (o_commit_valid),
    .o_commit_lanes    (o_commit_lanes),
    .o_commit_cmt_id   (o_commit_cmt_id),
    .o_flush_valid     (o_flush_valid),
    .o_flush_is_except (o_flush_is_except),
    .o_flush_cause     (o_flush_cause),
    .o_flush_tval      (o_flush_tval),
    .o_flush_addr      (o_flush_addr)
  );

endmodule

// ==== testbench/tb_rob.sv ====
`timescale 1ns/1ps
`include "rob_params.svh"

module tb_rob
  import rob_pkg::*;
();

  typedef struct packed {
    logic [7:0]       kind;
    logic [7:0][31:0] f;
  } cmd_t;

  typedef struct packed {
    logic [`ROB_ID_W-1:0]  id;
    logic [`DISP_SIZE-1:0] lanes;
  } commit_rec_t;

  typedef struct packed {
    logic        is_except;
    logic [3:0]  cause;
    logic [27:0] tval;
    logic [31:0] addr;
  } flush_rec_t;

  logic                     i_clk;
  logic                     i_reset_n;
  logic                     i_disp_valid;
  logic [`DISP_SIZE-1:0]    i_disp_lane_valid;
  logic [`VADDR_W-1:0]      i_disp_pc;
  logic [`DISP_SIZE-1:0]    i_disp_illegal;
  logic                     o_disp_ready;
  logic [`ROB_ID_W-1:0]     o_disp_cmt_id;
  logic [`CMT_BUS_SIZE-1:0] i_done_valid;
  logic [`ROB_ID_W-1:0]     i_done_cmt_id [`CMT_BUS_SIZE];
  logic [`LANE_W-1:0]       i_done_lane [`CMT_BUS_SIZE];
  logic [`CMT_BUS_SIZE-1:0] i_done_except;
  done_info_u               i_done_info [`CMT_BUS_SIZE];
  logic                     o_commit_valid;
  logic [`DISP_SIZE-1:0]    o_commit_lanes;
  logic [`ROB_ID_W-1:0]     o_commit_cmt_id;
  logic                     o_flush_valid;
  logic                     o_flush_is_except;
  except_e                  o_flush_cause;
  tval_t                    o_flush_tval;
  logic [`VADDR_W-1:0]      o_flush_addr;

  cmd_t        cmds [$];
  commit_rec_t exp_commit [$];
  flush_rec_t  exp_flush [$];
  int          commit_idx = 0;
  int          flush_idx = 0;
  int          n_lines = 0;
  bit          load_done = 1'b0;

  rob_top i_dut (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_disp_valid      (i_disp_valid),
    .i_disp_lane_valid (i_disp_lane_valid),
    .i_disp_pc         (i_disp_pc),
    .i_disp_illegal    (i_disp_illegal),
    .o_disp_ready      (o_disp_ready),
    .o_disp_cmt_id     (o_disp_cmt_id),
    .i_done_valid      (i_done_valid),
    .i_done_cmt_id     (i_done_cmt_id),
    .i_done_lane       (i_done_lane),
    .i_done_except     (i_done_except),
    .i_done_info       (i_done_info),
    .o_commit_valid    (o_commit_valid),
    .o_commit_lanes    (o_commit_lanes),
    .o_commit_cmt_id   (o_commit_cmt_id),
    .o_flush_valid     (o_flush_valid),
    .o_flush_is_except (o_flush_is_except),
    .o_flush_cause     (o_flush_cause),
    .o_flush_tval      (o_flush_tval),
    .o_flush_addr      (o_flush_addr)
  );

  always #2 i_clk = ~i_clk;  // 4 ns period

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else
      stop_run($sformatf("Mismatch at %0t: %s got 0x%0h expected 0x%0h",
                         $time, name, got, exp));
  endtask

  // --------------------------------------------------
  // Command file
  // --------------------------------------------------
  task automatic load_commands();
    int          fd;
    string       line;
    logic [7:0]  kind;
    logic [31:0] v [8];
    cmd_t        c;
    fd = $fopen("testbench/rob_testdata.txt", "r");
    assert (fd != 0) else stop_run("Could not open testbench/rob_testdata.txt");
    while (!$feof(fd)) begin
      line = "";
      kind = 8'h00;  // Blank lines parse to nothing
      void'($fgets(line, fd));
      foreach (v[i]) v[i] = '0;
      void'($sscanf(line, "%c %h %h %h %h %h %h %h %h",
                    kind, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]));
      case (kind)
        "D", "R", "Q", "K", "S": begin
          c.kind = kind;
          for (int i = 0; i < 8; i++) c.f[i] = v[i];
          if (kind == "S") begin  // Records listed so far
            c.f[0] = exp_commit.size();
            c.f[1] = exp_flush.size();
          end
          cmds.push_back(c);
          n_lines++;
        end
        "C": begin
          exp_commit.push_back({v[0][`ROB_ID_W-1:0], v[1][`DISP_SIZE-1:0]});
          n_lines++;
        end
        "F": begin
          exp_flush.push_back({v[0][0], v[1][3:0], v[2][27:0], v[3]});
          n_lines++;
        end
        default: ;
      endcase
    end
    $fclose(fd);
  endtask

  task automatic run_dispatch(input logic [31:0] lanes, input logic [31:0] pc,
                              input logic [31:0] illegal, input logic [31:0] exp_id);
    @(posedge i_clk);
    i_disp_valid      <= 1'b1;
    i_disp_lane_valid <= lanes[`DISP_SIZE-1:0];
    i_disp_pc         <= pc;
    i_disp_illegal    <= illegal[`DISP_SIZE-1:0];
    @(negedge i_clk);
    while (!o_disp_ready) begin  // Hold the request while full
      @(negedge i_clk);
    end
    check_value("o_disp_cmt_id", o_disp_cmt_id, exp_id);
    @(posedge i_clk);
    i_disp_valid <= 1'b0;
  endtask

  task automatic drive_report(input int p, input logic [31:0] id, input logic [31:0] lane,
                              input logic [31:0] exc, input logic [31:0] info);
    i_done_valid[p]  <= 1'b1;
    i_done_cmt_id[p] <= id[`ROB_ID_W-1:0];
    i_done_lane[p]   <= lane[`LANE_W-1:0];
    i_done_except[p] <= exc[0];
    i_done_info[p]   <= info;
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    int gap;
    i_clk             = 1'b0;
    i_reset_n         = 1'b0;
    i_disp_valid      = 1'b0;
    i_disp_lane_valid = '0;
    i_disp_pc         = '0;
    i_disp_illegal    = '0;
    i_done_valid      = '0;
    i_done_except     = '0;
    for (int p = 0; p < `CMT_BUS_SIZE; p++) begin
      i_done_cmt_id[p] = '0;
      i_done_lane[p]   = '0;
      i_done_info[p]   = '0;
    end
    void'($urandom(32'hb7eb));
    load_commands();
    load_done = 1'b1;
    repeat (16) @(posedge i_clk);
    i_reset_n <= 1'b1;

    foreach (cmds[k]) begin
      gap = 0;
      if (cmds[k].kind == "D" || cmds[k].kind == "R" || cmds[k].kind == "Q")
        gap = $urandom_range(3, 0);
      repeat (gap) @(posedge i_clk);
      case (cmds[k].kind)
        "D": run_dispatch(cmds[k].f[0], cmds[k].f[1], cmds[k].f[2], cmds[k].f[3]);
        "R": begin
          @(posedge i_clk);
          drive_report(cmds[k].f[0], cmds[k].f[1], cmds[k].f[2], cmds[k].f[3], cmds[k].f[4]);
          @(posedge i_clk);
          i_done_valid <= '0;
        end
        "Q": begin  // Both ports in one cycle
          @(posedge i_clk);
          drive_report(0, cmds[k].f[0], cmds[k].f[1], cmds[k].f[2], cmds[k].f[3]);
          drive_report(1, cmds[k].f[4], cmds[k].f[5], cmds[k].f[6], cmds[k].f[7]);
          @(posedge i_clk);
          i_done_valid <= '0;
        end
        "K": begin
          @(negedge i_clk);
          check_value("o_disp_ready", o_disp_ready, cmds[k].f[0]);
        end
        "S": wait (commit_idx >= cmds[k].f[0] && flush_idx >= cmds[k].f[1]);
        default: ;
      endcase
    end

    wait (commit_idx == exp_commit.size() && flush_idx == exp_flush.size());
    repeat (8) @(posedge i_clk);  // Catch stray pulses
    $display("STATUS: PASS");
    $finish;
  end

  // Outputs sampled mid-cycle
  always @(negedge i_clk) begin
    if (i_reset_n && o_commit_valid) begin
      assert (commit_idx < exp_commit.size()) else
        stop_run($sformatf("Commit pulse at %0t with no expected commit left", $time));
      check_value("o_commit_cmt_id", o_commit_cmt_id, exp_commit[commit_idx].id);
      check_value("o_commit_lanes", o_commit_lanes, exp_commit[commit_idx].lanes);
      commit_idx++;
    end
    if (i_reset_n && o_flush_valid) begin
      assert (flush_idx < exp_flush.size()) else
        stop_run($sformatf("Flush pulse at %0t with no expected flush left", $time));
      check_value("o_flush_is_except", o_flush_is_except, exp_flush[flush_idx].is_except);
      check_value("o_flush_cause", o_flush_cause, exp_flush[flush_idx].cause);
      check_value("o_flush_tval", o_flush_tval, exp_flush[flush_idx].tval);
      check_value("o_flush_addr", o_flush_addr, exp_flush[flush_idx].addr);
      flush_idx++;
    end
  end

  initial begin
    wait (load_done);
    repeat (16 + 40 * n_lines) @(posedge i_clk);
    stop_run($sformatf("Watchdog expired after %0d cycles without finishing the tests",
                       16 + 40 * n_lines));
  end

endmodule

// ==== build.f ====
+incdir+src
src/rob_pkg.sv
src/rob_dispatch.sv
src/rob_entry.sv
src/rob_buffer.sv
src/rob_commit.sv
src/rob_top.sv
testbench/tb_rob.sv

// ==== testbench/rob_testdata.txt ====
# D lanes pc illegal exp_id | R port id lane except info | K exp_ready | S wait for records
# Q id lane except info id lane except info (port 0, port 1) | C id lanes | F is_except cause tval addr
K 1
# One and two lane groups, reports out of order
D 3 00001000 0 0
D 1 00001008 0 1
D 3 00001010 0 2
R 0 2 1 0 00000000
R 1 1 0 0 00000000
R 0 0 1 0 00000000
R 1 2 0 0 00000000
R 0 0 0 0 00000000
C 0 3
C 1 1
C 2 3
S
# Both ports in one cycle
D 3 00002000 0 3
Q 3 0 0 00000000 3 1 0 00000000
C 3 3
S
# Redirect on lane 0 to 0x4000, group 5 flushed
D 3 00003000 0 4
D 1 00003100 0 5
R 1 4 1 0 00000000
R 0 4 0 0 80002000
C 4 1
F 0 0 0000000 00004000
S
# Load fault on lane 1, ids restart at 0
D 3 00005000 0 0
D 1 00005100 0 1
R 0 0 0 0 00000000
R 1 0 1 1 50000abc
C 0 1
F 1 5 0000abc 00005004
S
# Illegal lane 1, then an all-illegal group
D 3 00006000 2 0
R 0 0 0 0 00000000
C 0 1
F 1 2 0000000 00006004
S
D 1 00006100 1 0
F 1 2 0000000 00006100
S
# Eight groups fill the buffer, the ninth waits
D 1 00007000 0 0
D 1 00007010 0 1
D 1 00007020 0 2
D 1 00007030 0 3
D 1 00007040 0 4
D 1 00007050 0 5
D 1 00007060 0 6
D 1 00007070 0 7
K 0
R 0 0 0 0 00000000
D 1 00007080 0 0
Q 1 0 0 00000000 2 0 0 00000000
Q 3 0 0 00000000 4 0 0 00000000
Q 5 0 0 00000000 6 0 0 00000000
Q 7 0 0 00000000 0 0 0 00000000
C 0 1
C 1 1
C 2 1
C 3 1
C 4 1
C 5 1
C 6 1
C 7 1
C 0 1
S
